// ==== rtl/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller (
	input  logic                              clock,
	input  logic                              reset,

	// instruction cache
	input  mem_sys_pkg::bus_cmd_t             icache_command,
	input  logic [mem_sys_pkg::addr_w-1:0]    icache_addr,
	output mem_sys_pkg::mem_tag_t             icache_response,
	output logic [mem_sys_pkg::block_w-1:0]   icache_data,
	output mem_sys_pkg::mem_tag_t             icache_tag,

	// data cache
	input  mem_sys_pkg::bus_cmd_t             dcache_command,
	input  logic [mem_sys_pkg::addr_w-1:0]    dcache_addr,
	input  logic [mem_sys_pkg::block_w-1:0]   dcache_data,
	output mem_sys_pkg::mem_tag_t             dcache_response,
	output logic [mem_sys_pkg::block_w-1:0]   dcache_data_in,
	output mem_sys_pkg::mem_tag_t             dcache_tag,

	// memory
	output mem_sys_pkg::bus_cmd_t             proc2mem_command,
	output logic [mem_sys_pkg::addr_w-1:0]    proc2mem_addr,
	output logic [mem_sys_pkg::block_w-1:0]   proc2mem_data,
	input  mem_sys_pkg::mem_tag_t             mem2proc_response,
	input  logic [mem_sys_pkg::block_w-1:0]   mem2proc_data,
	input  mem_sys_pkg::mem_tag_t             mem2proc_tag
);
	import mem_sys_pkg::*;

	logic dsel;
	logic isel;

	// one bit per tag, set when the data cache owns it
	logic [tag_count-1:0] owner_d;
	logic                 ret_valid;
	logic                 ret_to_d;

	//////////////////////////////
	// request arbitration
	//////////////////////////////

	// data cache always wins
	assign dsel = (dcache_command != bus_none);
	assign isel = !dsel && (icache_command != bus_none);

	always_comb begin
		proc2mem_command = bus_none;
		proc2mem_addr    = icache_addr;
		proc2mem_data    = '0;
		if (dsel) begin
			proc2mem_command = dcache_command;
			proc2mem_addr    = dcache_addr;
			proc2mem_data    = dcache_data;
		end else if (isel) begin
			proc2mem_command = icache_command;
		end
	end

	// response only to the cache that was on the bus
	assign dcache_response = dsel ? mem2proc_response : '0;
	assign icache_response = isel ? mem2proc_response : '0;

	//////////////////////////////
	// tag owner table
	//////////////////////////////

	// stores never come back, so only loads are recorded
	always_ff @(posedge clock) begin
		if (reset) begin
			owner_d <= '0;
		end else if ((proc2mem_command == bus_load) && (mem2proc_response != '0)) begin
			owner_d[mem2proc_response] <= dsel;
		end
	end

	assign ret_valid = (mem2proc_tag != '0);
	assign ret_to_d  = owner_d[mem2proc_tag];

	// other cache sees tag zero
	assign dcache_tag     = (ret_valid && ret_to_d) ? mem2proc_tag : '0;
	assign dcache_data_in = (ret_valid && ret_to_d) ? mem2proc_data : '0;
	assign icache_tag     = (ret_valid && !ret_to_d) ? mem2proc_tag : '0;
	assign icache_data    = (ret_valid && !ret_to_d) ? mem2proc_data : '0;

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/100ps

module dcache #(
	parameter int dcache_lines = 32
) (
	input  logic                              clock,
	input  logic                              reset,

	// processor side
	input  mem_sys_pkg::bus_cmd_t             dmem_command,
	input  logic [mem_sys_pkg::addr_w-1:0]    dmem_addr,
	input  mem_sys_pkg::mem_size_t            dmem_size,
	input  logic [63:0]                       dmem_wdata,
	output logic [63:0]                       dmem_rdata,
	output logic                              dmem_finished,

	// controller side
	output mem_sys_pkg::bus_cmd_t             dcache_command,
	output logic [mem_sys_pkg::addr_w-1:0]    dcache_addr,
	output logic [mem_sys_pkg::block_w-1:0]   dcache_data,
	input  mem_sys_pkg::mem_tag_t             dcache_response,
	input  logic [mem_sys_pkg::block_w-1:0]   dcache_data_in,
	input  mem_sys_pkg::mem_tag_t             dcache_tag
);
	import mem_sys_pkg::*;

	localparam int idx_w  = $clog2(dcache_lines);
	localparam int ltag_w = addr_w - block_off_w - idx_w;

	//////////////////////////////
	// line storage
	//////////////////////////////

	logic [block_w-1:0]      data_mem [dcache_lines];
	logic [ltag_w-1:0]       tag_mem  [dcache_lines];
	logic [dcache_lines-1:0] valid_bits;

	// request address fields
	logic [idx_w-1:0]       req_idx;
	logic [ltag_w-1:0]      req_ltag;
	logic [block_off_w-1:0] req_off;
	logic [block_off_w+2:0] shamt;

	logic               is_load;
	logic               is_store;
	logic               hit;
	logic [block_w-1:0] line;

	// sized data path
	logic [block_w-1:0] size_mask;
	logic [block_w-1:0] byte_mask;
	logic [block_w-1:0] store_base;
	logic [block_w-1:0] merged;

	// outstanding load miss
	mem_tag_t          miss_tag;
	logic [idx_w-1:0]  miss_idx;
	logic [ltag_w-1:0] miss_ltag;

	logic load_issue;
	logic load_accept;
	logic store_accept;
	logic fill;

	assign req_idx  = dmem_addr[block_off_w +: idx_w];
	assign req_ltag = dmem_addr[addr_w-1 -: ltag_w];
	assign req_off  = dmem_addr[block_off_w-1:0];
	// byte offset to bit offset
	assign shamt    = {req_off, 3'b000};

	assign is_load  = (dmem_command == bus_load);
	assign is_store = (dmem_command == bus_store);

	assign line = data_mem[req_idx];
	assign hit  = valid_bits[req_idx] && (tag_mem[req_idx] == req_ltag);

	//////////////////////////////
	// size handling
	//////////////////////////////

	always_comb begin
		case (dmem_size)
			size_byte: size_mask = 64'h0000_0000_0000_00ff;
			size_half: size_mask = 64'h0000_0000_0000_ffff;
			size_word: size_mask = 64'h0000_0000_ffff_ffff;
			default:   size_mask = '1;
		endcase
	end

	// load result, slice shifted down and zero-extended
	assign dmem_rdata = (line >> shamt) & size_mask;

	// store image over the cached line, or over zeros on a miss
	assign byte_mask  = size_mask << shamt;
	assign store_base = hit ? line : '0;
	assign merged     = (store_base & ~byte_mask) | ((dmem_wdata << shamt) & byte_mask);

	//////////////////////////////
	// bus requests
	//////////////////////////////

	// load miss asks once nothing else is outstanding
	assign load_issue = is_load && !hit && (miss_tag == '0);

	always_comb begin
		if (is_store) begin
			dcache_command = bus_store;
		end else if (load_issue) begin
			dcache_command = bus_load;
		end else begin
			dcache_command = bus_none;
		end
	end

	// whole aligned block every time
	assign dcache_addr = block_addr(dmem_addr);
	assign dcache_data = merged;

	assign load_accept  = load_issue && (dcache_response != '0);
	// store is done when memory takes it
	assign store_accept = is_store && (dcache_response != '0);
	assign fill         = (miss_tag != '0) && (dcache_tag == miss_tag);

	// hit load finishes at once, miss load on the hit after its fill
	assign dmem_finished = (is_load && hit) || store_accept;

	always_ff @(posedge clock) begin
		if (reset) begin
			miss_tag <= '0;
		end else if (load_accept) begin
			miss_tag <= dcache_response;
		end else if (fill) begin
			miss_tag <= '0;
		end
	end

	// line and tag of the load in flight
	always_ff @(posedge clock) begin
		if (load_accept) begin
			miss_idx  <= req_idx;
			miss_ltag <= req_ltag;
		end
	end

	//////////////////////////////
	// line updates
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (fill) begin
			data_mem[miss_idx] <= dcache_data_in;
			tag_mem[miss_idx]  <= miss_ltag;
		end else if (store_accept && hit) begin
			// write-through hit keeps the line in step with memory
			data_mem[req_idx] <= merged;
		end
	end

	// store miss does not allocate
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (fill) begin
			valid_bits[miss_idx] <= 1'b1;
		end
	end

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/100ps

module icache #(
	parameter int icache_lines = 32
) (
	input  logic                              clock,
	input  logic                              reset,

	// fetch side
	input  logic [mem_sys_pkg::addr_w-1:0]    fetch_addr,
	output logic [mem_sys_pkg::block_w-1:0]   fetch_data,
	output logic                              fetch_valid,

	// controller side
	output mem_sys_pkg::bus_cmd_t             icache_command,
	output logic [mem_sys_pkg::addr_w-1:0]    icache_addr,
	input  mem_sys_pkg::mem_tag_t             icache_response,
	input  logic [mem_sys_pkg::block_w-1:0]   icache_data,
	input  mem_sys_pkg::mem_tag_t             icache_tag
);
	import mem_sys_pkg::*;

	localparam int idx_w  = $clog2(icache_lines);
	localparam int ltag_w = addr_w - block_off_w - idx_w;

	//////////////////////////////
	// line storage
	//////////////////////////////

	logic [block_w-1:0]      data_mem [icache_lines];
	logic [ltag_w-1:0]       tag_mem  [icache_lines];
	logic [icache_lines-1:0] valid_bits;

	// fields of the current fetch address
	logic [idx_w-1:0]  fetch_idx;
	logic [ltag_w-1:0] fetch_ltag;
	logic              hit;

	// miss tracking
	logic              req_active;
	mem_tag_t          miss_tag;
	logic [addr_w-1:0] miss_addr;
	logic [idx_w-1:0]  miss_idx;
	logic [ltag_w-1:0] miss_ltag;

	logic start_miss;
	logic accepted;
	logic fill;

	assign fetch_idx  = fetch_addr[block_off_w +: idx_w];
	assign fetch_ltag = fetch_addr[addr_w-1 -: ltag_w];

	// hit check against the indexed line
	assign hit         = valid_bits[fetch_idx] && (tag_mem[fetch_idx] == fetch_ltag);
	assign fetch_valid = hit;
	assign fetch_data  = data_mem[fetch_idx];

	//////////////////////////////
	// miss handling
	//////////////////////////////

	// only one miss in flight, requested or waiting for data
	assign start_miss = !hit && !req_active && (miss_tag == '0);

	// request comes from the recorded miss address
	assign miss_idx       = miss_addr[block_off_w +: idx_w];
	assign miss_ltag      = miss_addr[addr_w-1 -: ltag_w];
	assign icache_command = req_active ? bus_load : bus_none;
	assign icache_addr    = miss_addr;

	// nonzero response means memory took the load
	assign accepted = req_active && (icache_response != '0);

	// data for our tag is back
	assign fill = (miss_tag != '0) && (icache_tag == miss_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			req_active <= 1'b0;
			miss_tag   <= '0;
		end else if (start_miss) begin
			req_active <= 1'b1;
		end else if (accepted) begin
			// stop asking, wait for the tag
			req_active <= 1'b0;
			miss_tag   <= icache_response;
		end else if (fill) begin
			miss_tag <= '0;
		end
	end

	// block address of the miss, held until the fill
	always_ff @(posedge clock) begin
		if (start_miss) begin
			miss_addr <= block_addr(fetch_addr);
		end
	end

	//////////////////////////////
	// line fill
	//////////////////////////////

	// fill goes to the recorded line even if fetch_addr moved
	always_ff @(posedge clock) begin
		if (fill) begin
			data_mem[miss_idx] <= icache_data;
			tag_mem[miss_idx]  <= miss_ltag;
		end
	end

	// all lines invalid out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (fill) begin
			valid_bits[miss_idx] <= 1'b1;
		end
	end

endmodule

// ==== rtl/mem_sys_pkg.sv ====
package mem_sys_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// byte address, one word wide
	localparam int addr_w = 32;

	// one memory block = one cache line = one double word
	localparam int block_w = 64;

	// byte offset bits inside a block
	localparam int block_off_w = $clog2(block_w / 8);

	// memory transaction tag, zero means no tag
	localparam int tag_w = 4;

	// number of distinct tag values
	localparam int tag_count = 2 ** tag_w;

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic [tag_w-1:0] mem_tag_t;

	// bus command, same encoding as the memory bus
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_cmd_t;

	// access size of a load or store
	typedef enum logic [1:0] {
		size_byte   = 2'h0,
		size_half   = 2'h1,
		size_word   = 2'h2,
		size_double = 2'h3
	} mem_size_t;

	//////////////////////////////
	// helpers
	//////////////////////////////

	// aligned block address, low offset bits cleared
	function automatic logic [addr_w-1:0] block_addr(input logic [addr_w-1:0] addr);
		return {addr[addr_w-1:block_off_w], {block_off_w{1'b0}}};
	endfunction

endpackage

// ==== rtl/mem_sys_top.sv ====
`timescale 1ns/100ps

module mem_sys_top #(
	parameter int icache_lines = 32,
	parameter int dcache_lines = 32
) (
	input  logic                              clock,
	input  logic                              reset,

	// memory bus
	input  mem_sys_pkg::mem_tag_t             mem2proc_response,
	input  logic [mem_sys_pkg::block_w-1:0]   mem2proc_data,
	input  mem_sys_pkg::mem_tag_t             mem2proc_tag,
	output mem_sys_pkg::bus_cmd_t             proc2mem_command,
	output logic [mem_sys_pkg::addr_w-1:0]    proc2mem_addr,
	output logic [mem_sys_pkg::block_w-1:0]   proc2mem_data,

	// fetch port
	input  logic [mem_sys_pkg::addr_w-1:0]    fetch_addr,
	output logic [mem_sys_pkg::block_w-1:0]   fetch_data,
	output logic                              fetch_valid,

	// data port
	input  mem_sys_pkg::bus_cmd_t             dmem_command,
	input  logic [mem_sys_pkg::addr_w-1:0]    dmem_addr,
	input  mem_sys_pkg::mem_size_t            dmem_size,
	input  logic [63:0]                       dmem_wdata,
	output logic [63:0]                       dmem_rdata,
	output logic                              dmem_finished
);
	import mem_sys_pkg::*;

	//////////////////////////////
	// cache to controller
	//////////////////////////////

	bus_cmd_t           icache_command;
	logic [addr_w-1:0]  icache_addr;
	mem_tag_t           icache_response;
	logic [block_w-1:0] icache_data;
	mem_tag_t           icache_tag;

	bus_cmd_t           dcache_command;
	logic [addr_w-1:0]  dcache_addr;
	logic [block_w-1:0] dcache_data;
	mem_tag_t           dcache_response;
	logic [block_w-1:0] dcache_data_in;
	mem_tag_t           dcache_tag;

	icache #(
		.icache_lines(icache_lines)
	) icache_0 (
		.clock           (clock),
		.reset           (reset),
		.fetch_addr      (fetch_addr),
		.fetch_data      (fetch_data),
		.fetch_valid     (fetch_valid),
		.icache_command  (icache_command),
		.icache_addr     (icache_addr),
		.icache_response (icache_response),
		.icache_data     (icache_data),
		.icache_tag      (icache_tag)
	);

	dcache #(
		.dcache_lines(dcache_lines)
	) dcache_0 (
		.clock           (clock),
		.reset           (reset),
		.dmem_command    (dmem_command),
		.dmem_addr       (dmem_addr),
		.dmem_size       (dmem_size),
		.dmem_wdata      (dmem_wdata),
		.dmem_rdata      (dmem_rdata),
		.dmem_finished   (dmem_finished),
		.dcache_command  (dcache_command),
		.dcache_addr     (dcache_addr),
		.dcache_data     (dcache_data),
		.dcache_response (dcache_response),
		.dcache_data_in  (dcache_data_in),
		.dcache_tag      (dcache_tag)
	);

	// merges both miss streams onto the one bus
	cache_controller cache_controller_0 (
		.clock             (clock),
		.reset             (reset),
		.icache_command    (icache_command),
		.icache_addr       (icache_addr),
		.icache_response   (icache_response),
		.icache_data       (icache_data),
		.icache_tag        (icache_tag),
		.dcache_command    (dcache_command),
		.dcache_addr       (dcache_addr),
		.dcache_data       (dcache_data),
		.dcache_response   (dcache_response),
		.dcache_data_in    (dcache_data_in),
		.dcache_tag        (dcache_tag),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.mem2proc_response (mem2proc_response),
		.mem2proc_data     (mem2proc_data),
		.mem2proc_tag      (mem2proc_tag)
	);

endmodule

// ==== sim.f ====
rtl/mem_sys_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/cache_controller.sv
rtl/mem_sys_top.sv
test/mem_model.sv
test/mem_sys_tb.sv

// ==== test/mem_model.sv ====
`timescale 1ns/100ps

module mem_model #(
	parameter int latency = 4
) (
	input  logic                              clock,
	input  logic                              reset,
	// high when memory is free this cycle
	input  logic                              grant,
	input  mem_sys_pkg::bus_cmd_t             proc2mem_command,
	input  logic [mem_sys_pkg::addr_w-1:0]    proc2mem_addr,
	input  logic [mem_sys_pkg::block_w-1:0]   proc2mem_data,
	output mem_sys_pkg::mem_tag_t             mem2proc_response,
	output logic [mem_sys_pkg::block_w-1:0]   mem2proc_data,
	output mem_sys_pkg::mem_tag_t             mem2proc_tag
);
	import mem_sys_pkg::*;

	// only stored blocks live here, the rest follow the power-up rule
	logic [block_w-1:0] blocks [logic [addr_w-1:0]];
	mem_tag_t           next_tag;
	mem_tag_t           tag_pipe  [latency];
	logic [block_w-1:0] data_pipe [latency];
	mem_tag_t           ret_tag  = '0;
	logic [block_w-1:0] ret_data = '0;

	// accept in the same cycle as the command
	assign mem2proc_response = (!reset && grant && proc2mem_command != bus_none) ? next_tag : '0;
	assign mem2proc_tag      = ret_tag;
	assign mem2proc_data     = ret_data;

	// inverted address on top, address below
	function automatic logic [block_w-1:0] read_block(input logic [addr_w-1:0] addr);
		if (blocks.exists(addr)) begin
			return blocks[addr];
		end
		return {~addr, addr};
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			next_tag <= mem_tag_t'(1);
			for (int i = 0; i < latency; i++) begin
				tag_pipe[i]  <= '0;
				data_pipe[i] <= '0;
			end
		end else begin
			tag_pipe[0] <= '0;
			if (mem2proc_response != '0) begin
				// tags 1 to 15 in turn
				next_tag <= (next_tag == mem_tag_t'(tag_count - 1)) ? mem_tag_t'(1) : next_tag + 1'b1;
				if (proc2mem_command == bus_load) begin
					tag_pipe[0]  <= mem2proc_response;
					data_pipe[0] <= read_block(proc2mem_addr);
				end else begin
					blocks[proc2mem_addr] = proc2mem_data;
				end
			end
			for (int i = 1; i < latency; i++) begin
				tag_pipe[i]  <= tag_pipe[i-1];
				data_pipe[i] <= data_pipe[i-1];
			end
		end
	end

	// return side changes on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			ret_tag  <= '0;
			ret_data <= '0;
		end else begin
			ret_tag  <= tag_pipe[latency-1];
			ret_data <= data_pipe[latency-1];
		end
	end

endmodule

// ==== test/mem_sys_tb.sv ====
`timescale 1ns/100ps

module mem_sys_tb;
	import mem_sys_pkg::*;

	localparam int period       = 20;
	localparam int sample_dly   = period / 2 - 1;
	localparam int reset_cycles = 16;
	localparam int mem_latency  = 4;
	localparam int num_tests    = 5;
	localparam int test_cycles  = 1000;
	localparam int mix_rounds   = 8;
	localparam int lines        = 32;
	localparam logic [31:0] seed = 32'h8c72;

	// load hit modes
	localparam int any_hit   = 0;
	localparam int must_hit  = 1;
	localparam int must_miss = 2;

	logic               clock;
	logic               reset;
	logic               grant;
	mem_tag_t           mem2proc_response;
	logic [block_w-1:0] mem2proc_data;
	mem_tag_t           mem2proc_tag;
	bus_cmd_t           proc2mem_command;
	logic [addr_w-1:0]  proc2mem_addr;
	logic [block_w-1:0] proc2mem_data;
	logic [addr_w-1:0]  fetch_addr;
	logic [block_w-1:0] fetch_data;
	logic               fetch_valid;
	bus_cmd_t           dmem_command;
	logic [addr_w-1:0]  dmem_addr;
	mem_size_t          dmem_size;
	logic [63:0]        dmem_wdata;
	logic [63:0]        dmem_rdata;
	logic               dmem_finished;

	int          value_errors;
	int          other_errors;
	logic [31:0] busy_lfsr;
	logic [31:0] addr_lfsr;
	// blocks stored so far by aligned address
	logic [63:0] written [logic [31:0]];

	mem_sys_top #(
		.icache_lines(lines),
		.dcache_lines(lines)
	) UUT (
		.clock(clock), .reset(reset),
		.mem2proc_response(mem2proc_response), .mem2proc_data(mem2proc_data),
		.mem2proc_tag(mem2proc_tag), .proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr), .proc2mem_data(proc2mem_data),
		.fetch_addr(fetch_addr), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
		.dmem_command(dmem_command), .dmem_addr(dmem_addr), .dmem_size(dmem_size),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_finished(dmem_finished)
	);

	mem_model #(
		.latency(mem_latency)
	) memory (
		.clock(clock), .reset(reset), .grant(grant),
		.proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
		.proc2mem_data(proc2mem_data), .mem2proc_response(mem2proc_response),
		.mem2proc_data(mem2proc_data), .mem2proc_tag(mem2proc_tag)
	);

	always #(period / 2) clock = ~clock;

	//////////////////////////////
	// helpers
	//////////////////////////////

	// galois step for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], addr_lfsr[0]};
			addr_lfsr = lfsr_next(addr_lfsr);
		end
		return r;
	endfunction

	function automatic logic [31:0] block_of(input logic [31:0] addr);
		return addr & ~32'h7;
	endfunction

	// memory contents at power up
	function automatic logic [63:0] rule_block(input logic [31:0] addr);
		return {~block_of(addr), block_of(addr)};
	endfunction

	function automatic logic [63:0] expected_block(input logic [31:0] addr);
		if (written.exists(block_of(addr))) begin
			return written[block_of(addr)];
		end
		return rule_block(addr);
	endfunction

	// addressed bytes moved down with zeros above
	function automatic logic [63:0] slice_of(input logic [63:0] blk, input logic [31:0] addr,
			input mem_size_t size);
		logic [63:0] r;
		int off;
		r = '0;
		off = addr[2:0];
		for (int b = 0; b < (1 << int'(size)); b++) begin
			if (off + b < 8) begin
				r[b*8 +: 8] = blk[(off+b)*8 +: 8];
			end
		end
		return r;
	endfunction

	function automatic logic [63:0] merge_store(input logic [63:0] base, input logic [31:0] addr,
			input mem_size_t size, input logic [63:0] wdata);
		logic [63:0] r;
		int off;
		r = base;
		off = addr[2:0];
		for (int b = 0; b < (1 << int'(size)); b++) begin
			if (off + b < 8) begin
				r[(off+b)*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return r;
	endfunction

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		value_errors++;
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic other_error(input string what);
		other_errors++;
		$display("at %0t: %s", $time, what);
	endtask

	//////////////////////////////
	// bus drivers
	//////////////////////////////

	// hold the fetch address until the block is valid
	task automatic fetch_block(input logic [31:0] addr, output logic [63:0] data,
			output int waits);
		@(negedge clock);
		fetch_addr = addr;
		waits = 0;
		#(sample_dly);
		while (fetch_valid !== 1'b1) begin
			@(negedge clock);
			#(sample_dly);
			waits++;
		end
		data = fetch_data;
	endtask

	// one data access with the command dropped in the cycle after finished
	task automatic data_access(input bus_cmd_t cmd, input logic [31:0] addr, input mem_size_t size,
			input logic [63:0] wdata, output logic [63:0] rdata, output int waits);
		@(negedge clock);
		dmem_command = cmd;
		dmem_addr    = addr;
		dmem_size    = size;
		dmem_wdata   = wdata;
		waits        = 0;
		#(sample_dly);
		while (dmem_finished !== 1'b1) begin
			@(negedge clock);
			#(sample_dly);
			waits++;
		end
		rdata = dmem_rdata;
		@(negedge clock);
		dmem_command = bus_none;
	endtask

	task automatic load_check(input logic [31:0] addr, input mem_size_t size, input int hit_mode);
		logic [63:0] rdata;
		logic [63:0] exp;
		int waits;
		data_access(bus_load, addr, size, '0, rdata, waits);
		exp = slice_of(expected_block(addr), addr, size);
		if (rdata !== exp) begin
			value_error("dmem_rdata", rdata, exp);
		end
		if (hit_mode == must_hit && waits != 0) begin
			other_error($sformatf("load at %h missed but the block was cached", addr));
		end
		if (hit_mode == must_miss && waits == 0) begin
			other_error($sformatf("load at %h hit a block that was not cached", addr));
		end
	endtask

	// write-through base is the line on a hit and zero on a miss
	task automatic store_check(input logic [31:0] addr, input mem_size_t size,
			input logic [63:0] wdata, input logic cached);
		logic [63:0] base;
		logic [63:0] rdata;
		int waits;
		base = cached ? expected_block(addr) : '0;
		written[block_of(addr)] = merge_store(base, addr, size, wdata);
		data_access(bus_store, addr, size, wdata, rdata, waits);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic reset_state();
		for (int i = 0; i < reset_cycles; i++) begin
			@(negedge clock);
			// last pass is the first cycle out of reset
			if (i == reset_cycles - 1) begin
				reset = 1'b0;
			end
			#(sample_dly);
			if (proc2mem_command !== bus_none) begin
				value_error("proc2mem_command", proc2mem_command, bus_none);
			end
			if (fetch_valid !== 1'b0) begin
				value_error("fetch_valid", fetch_valid, 1'b0);
			end
			if (dmem_finished !== 1'b0) begin
				value_error("dmem_finished", dmem_finished, 1'b0);
			end
		end
	endtask

	task automatic fetch_sequence();
		logic [63:0] data;
		int waits;
		fetch_block(32'h0000_1040, data, waits);
		if (data !== rule_block(32'h0000_1040)) begin
			value_error("fetch_data", data, rule_block(32'h0000_1040));
		end
		// same block but another word
		fetch_block(32'h0000_1044, data, waits);
		if (waits != 0) begin
			other_error("repeat fetch of a cached block did not hit at once");
		end
		if (data !== rule_block(32'h0000_1044)) begin
			value_error("fetch_data", data, rule_block(32'h0000_1044));
		end
		// same index with another tag
		fetch_block(32'h0000_1040 + lines * 8, data, waits);
		if (waits == 0) begin
			other_error("fetch with a new tag hit the old line");
		end
		if (data !== rule_block(32'h0000_1040 + lines * 8)) begin
			value_error("fetch_data", data, rule_block(32'h0000_1040 + lines * 8));
		end
	endtask

	task automatic sized_loads();
		logic [31:0] base;
		int hi;
		for (int s = 0; s < 4; s++) begin
			base = 32'h0000_5000 + s * 32'h48;
			hi = 8 - (1 << s);
			load_check(base, mem_size_t'(s), must_miss);
			load_check(base + hi, mem_size_t'(s), must_hit);
			load_check(base, mem_size_t'(s), must_hit);
		end
	endtask

	task automatic sized_stores();
		mem_size_t   sizes [4];
		int          offs  [4];
		logic [63:0] wdata;
		logic [63:0] data;
		int waits;
		sizes = '{size_double, size_byte, size_half, size_word};
		offs  = '{0, 5, 2, 4};
		load_check(32'h0000_6010, size_double, must_miss);
		for (int i = 0; i < 4; i++) begin
			wdata[63:32] = take_bits(32);
			wdata[31:0]  = take_bits(32);
			store_check(32'h0000_6010 + offs[i], sizes[i], wdata, 1'b1);
			load_check(32'h0000_6010, size_double, must_hit);
			load_check(32'h0000_6010 + offs[i], sizes[i], must_hit);
		end
		// miss leaves zeros around the word
		store_check(32'h0000_702c, size_word, 64'h0000_0000_cafe_f00d, 1'b0);
		load_check(32'h0000_7028, size_double, must_miss);
		// read memory back through the instruction side
		fetch_block(32'h0000_6010, data, waits);
		if (data !== expected_block(32'h0000_6010)) begin
			value_error("fetch_data", data, expected_block(32'h0000_6010));
		end
		fetch_block(32'h0000_7028, data, waits);
		if (data !== expected_block(32'h0000_7028)) begin
			value_error("fetch_data", data, expected_block(32'h0000_7028));
		end
	endtask

	task automatic concurrent_misses();
		logic [31:0] fa;
		logic [31:0] da;
		logic [63:0] fdata;
		logic [63:0] wdata;
		int fwaits;
		for (int r = 0; r < mix_rounds; r++) begin
			fa = 32'h0004_0000 | (take_bits(8) << 3);
			da = 32'h0008_0000 | (take_bits(8) << 3);
			wdata[63:32] = take_bits(32);
			wdata[31:0]  = take_bits(32);
			// odd rounds store so a held store meets a fetch miss
			fork
				fetch_block(fa, fdata, fwaits);
				if (r % 2 == 1) begin
					store_check(da, size_double, wdata, 1'b0);
				end else begin
					load_check(da, size_double, any_hit);
				end
			join
			if (fdata !== expected_block(fa)) begin
				value_error("fetch_data", fdata, expected_block(fa));
			end
			if (r % 2 == 1) begin
				load_check(da, size_double, any_hit);
			end
		end
	endtask

	//////////////////////////////
	// monitors and main
	//////////////////////////////

	// memory busy cycles
	always @(negedge clock) begin
		grant = busy_lfsr[0];
		busy_lfsr = lfsr_next(busy_lfsr);
	end

	// data cache owns the bus when both ask
	always begin
		@(negedge clock);
		#(sample_dly);
		if (!reset && UUT.dcache_command != bus_none && UUT.icache_command != bus_none) begin
			if (proc2mem_command !== dmem_command) begin
				value_error("proc2mem_command", proc2mem_command, dmem_command);
			end
			if (proc2mem_addr !== block_of(dmem_addr)) begin
				value_error("proc2mem_addr", proc2mem_addr, block_of(dmem_addr));
			end
		end
	end

	initial begin
		#(num_tests * test_cycles * period);
		other_error("watchdog expired before the tests finished");
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		$display("Errors found");
		$finish;
	end

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		grant        = 1'b0;
		fetch_addr   = '0;
		dmem_command = bus_none;
		dmem_addr    = '0;
		dmem_size    = size_byte;
		dmem_wdata   = '0;
		busy_lfsr    = seed;
		addr_lfsr    = seed;
		value_errors = 0;
		other_errors = 0;
		reset_state();
		fetch_sequence();
		sized_loads();
		sized_stores();
		concurrent_misses();
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
